// ==== sim.f ====
src/CryptPkg.sv
src/SyncFifo.sv
src/BucketFramer.sv
src/KeystreamGen.sv
src/OutputStage.sv
src/PathCrypt.sv
bench/ClockGen.sv
bench/PathCryptChecker.sv
bench/tbPathCrypt.sv

// ==== Bender.yml ====
package:
  name: path_crypt

sources:
  - src/CryptPkg.sv
  - src/SyncFifo.sv
  - src/BucketFramer.sv
  - src/KeystreamGen.sv
  - src/OutputStage.sv
  - src/PathCrypt.sv
  - target: test
    files:
      - bench/ClockGen.sv
      - bench/PathCryptChecker.sv
      - bench/tbPathCrypt.sv

// ==== bench/tbPathCrypt.sv ====
/*
 * Testbench top: a path read driven from a stimulus table, then its
 * backend output fed back in as the following path write
 */
module tbPathCrypt;
    import CryptPkg::*;

    localparam int Bursts    = 2 * PathBursts;
    localparam int Period    = 100;
    localparam int DriveSkew = 10;
    localparam int Timeout   = 4 * Bursts * (KeystreamLatency + FifoDepth) * Period;

    logic      Clock;
    logic      rstN;
    BurstWordT migIn;
    logic      migInValid;
    logic      migInReady;
    BurstWordT migOut;
    logic      migOutValid;
    logic      migOutReady;
    BurstWordT backendWData;
    logic      backendWValid;
    logic      backendWReady;
    BurstWordT backendRData;
    logic      backendRValid;
    logic      backendRReady;
    logic      dramInitDone;
    int        transfers;
    int        valueErrors;
    int        otherErrors;
    logic      readyDropSeen;

    // Stimulus table, path 2 rows are taken from the path 1 output
    BurstWordT stimWord [Bursts];
    int        stallLen [Bursts];
    logic      expectRead [Bursts];
    IvT        bucketIv [PathBuckets];
    BurstWordT capturedQ[$];
    int        seed = 86153;
    int        stallIdx = 0;
    int        waited = 0;
    int        localErrors = 0;

    ClockGen #(.Period(Period), .ResetCycles(2)) clockGen (.Clock, .rstN);

    PathCrypt dut_i (
        .Clock, .rstN,
        .migIn, .migInValid, .migInReady,
        .migOut, .migOutValid, .migOutReady,
        .backendWData, .backendWValid, .backendWReady,
        .backendRData, .backendRValid, .backendRReady,
        .dramInitDone
    );

    PathCryptChecker pathChecker (
        .Clock, .rstN, .dramInitDone,
        .migIn, .migInValid, .migInReady,
        .backendWData, .backendWValid, .backendWReady,
        .migOut, .migOutValid, .migOutReady,
        .backendRData, .backendRValid, .backendRReady,
        .transfers, .valueErrors, .otherErrors, .readyDropSeen
    );

    task automatic sendBurst(input BurstWordT w, input logic fromDram);
        logic taken;
        migIn         = w;
        backendWData  = w;
        migInValid    = fromDram;
        backendWValid = !fromDram;
        taken         = 1'b0;
        while (!taken) begin
            @(negedge Clock);
            taken = fromDram ? migInReady : backendWReady;
            @(posedge Clock);
            #DriveSkew;
        end
        migInValid    = 1'b0;
        backendWValid = 1'b0;
    endtask

    // Stall the expected destination for the table's count of busy cycles
    always @(posedge Clock) begin
        #DriveSkew;
        if (transfers != stallIdx) begin
            stallIdx = transfers;
            waited   = 0;
        end
        if (stallIdx < Bursts && waited < stallLen[stallIdx] && (migOutValid || backendRValid)) begin
            waited++;
            backendRReady = !expectRead[stallIdx];
            migOutReady   = expectRead[stallIdx];
        end else begin
            backendRReady = 1'b1;
            migOutReady   = 1'b1;
        end
    end

    always @(negedge Clock) begin
        if (rstN && backendRValid && backendRReady) begin
            capturedQ.push_back(backendRData);
        end
    end

    initial begin
        migIn         = '0;
        migInValid    = 1'b0;
        backendWData  = '0;
        backendWValid = 1'b0;
        migOutReady   = 1'b1;
        backendRReady = 1'b1;
        dramInitDone  = 1'b0;
        // One IV wraps past 32 bits inside its bucket
        bucketIv[0] = 32'h0000_0001;
        bucketIv[1] = 32'hFFFF_FFFE;
        bucketIv[2] = 32'h8BAD_F00D;
        for (int i = 0; i < Bursts; i++) begin
            stimWord[i].raw = {$random(seed), $random(seed), $random(seed), $random(seed)};
            if (i < PathBursts && i % BucketBursts == 0) begin
                stimWord[i].header.iv = bucketIv[i / BucketBursts];
            end
            stallLen[i]   = $random(seed) & 3;
            expectRead[i] = (i < PathBursts);
        end
        // Long enough to fill the data FIFO
        stallLen[1]              = 3 * FifoDepth;
        stallLen[PathBursts + 1] = 3 * FifoDepth;

        while (rstN !== 1'b1) begin
            @(posedge Clock);
        end
        repeat (3) @(posedge Clock);
        #DriveSkew;
        dramInitDone = 1'b1;
        for (int i = 0; i < PathBursts; i++) begin
            sendBurst(stimWord[i], 1'b1);
        end
        for (int i = PathBursts; i < Bursts; i++) begin
            while (capturedQ.size() == 0) begin
                @(posedge Clock);
                #DriveSkew;
            end
            stimWord[i] = capturedQ.pop_front();
            sendBurst(stimWord[i], 1'b0);
        end
        while (transfers < Bursts) begin
            @(posedge Clock);
        end
        // A few idle cycles to catch stray outputs
        repeat (2 * ResultDepth) @(posedge Clock);
        if (!readyDropSeen) begin
            $display("Input ready never fell while the output was stalled");
            localErrors++;
        end
        $display("Errors: %0d value mismatches, %0d other failures",
                 valueErrors, otherErrors + localErrors);
        if (valueErrors + otherErrors + localErrors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(Timeout);
        $display("Run timed out after %0d of %0d output bursts", transfers, Bursts);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== bench/PathCryptChecker.sv ====
/*
 * Testbench checker: predicts each output burst from the accepted
 * inputs and compares what the DUT sends on either side
 */
module PathCryptChecker (
    input  logic                Clock,
    input  logic                rstN,
    input  logic                dramInitDone,
    input  CryptPkg::BurstWordT migIn,
    input  logic                migInValid,
    input  logic                migInReady,
    input  CryptPkg::BurstWordT backendWData,
    input  logic                backendWValid,
    input  logic                backendWReady,
    input  CryptPkg::BurstWordT migOut,
    input  logic                migOutValid,
    input  logic                migOutReady,
    input  CryptPkg::BurstWordT backendRData,
    input  logic                backendRValid,
    input  logic                backendRReady,
    output int                  transfers,
    output int                  valueErrors,
    output int                  otherErrors,
    output logic                readyDropSeen
);
    import CryptPkg::*;

    BurstWordT expectQ[$];
    BurstWordT originalQ[$];
    IvT        bucketIv;
    int        inPos;
    logic      initSeen;

    // Each lane counter goes through the keyed rounds on its own
    function automatic logic [BurstWidth-1:0] keystream(input IvT iv, input int idx);
        logic [BurstWidth-1:0] ks;
        logic [63:0]           x;
        for (int n = 0; n < Lanes; n++) begin
            x = 64'(iv) + 64'(idx * Lanes + n);
            for (int s = 0; s < KeystreamLatency; s++) begin
                x = x ^ ((CipherKey << (8 * s)) | (CipherKey >> (64 - 8 * s)));
                x = {x[50:0], x[63:51]} + MixConstant;
            end
            ks[n*64 +: 64] = x;
        end
        return ks;
    endfunction

    task automatic predict(input BurstWordT w, input logic fromDram);
        BurstWordT e;
        if (inPos == 0) begin
            bucketIv = w.header.iv;
        end
        e.raw = w.raw ^ keystream(bucketIv, inPos);
        // Header IV goes out untouched
        if (inPos == 0) begin
            e.header.iv = bucketIv;
        end
        expectQ.push_back(e);
        if (fromDram) begin
            originalQ.push_back(w);
        end
        inPos = (inPos + 1) % BucketBursts;
    endtask

    task automatic compare(input string name, input BurstWordT expected,
                           input BurstWordT actual);
        if (actual !== expected) begin
            $display("FAIL %s burst %0d: expected %h, actual %h",
                     name, transfers, expected.raw, actual.raw);
            valueErrors++;
        end
    endtask

    task automatic checkOutput(input BurstWordT actual, input logic onBackend);
        // Even-numbered paths are reads toward the backend
        if (onBackend != ((transfers / PathBursts) % 2 == 0)) begin
            $display("Burst %0d left on the wrong side", transfers);
            otherErrors++;
        end
        if (expectQ.size() == 0 || (!onBackend && originalQ.size() == 0)) begin
            $display("Burst %0d was sent with no input burst to match it", transfers);
            otherErrors++;
        end else begin
            compare(onBackend ? "decrypt" : "encrypt", expectQ.pop_front(), actual);
            if (!onBackend) begin
                compare("roundTrip", originalQ.pop_front(), actual);
            end
        end
        transfers++;
    endtask

    initial begin
        transfers     = 0;
        valueErrors   = 0;
        otherErrors   = 0;
        readyDropSeen = 1'b0;
        inPos         = 0;
        initSeen      = 1'b0;
    end

    // --------------------
    // Sampling mid-cycle
    // --------------------
    always @(negedge Clock) begin
        if (!rstN) begin
            if (migOutValid !== 1'b0 || backendRValid !== 1'b0 ||
                migInReady !== 1'b0 || backendWReady !== 1'b0) begin
                $display("An output valid or input ready was high during reset");
                otherErrors++;
            end
        end else begin
            if ((migOutValid || backendRValid) && !initSeen) begin
                $display("An output was valid before initialisation completed");
                otherErrors++;
            end
            if (migOutValid && backendRValid) begin
                $display("Both output sides were valid in the same cycle");
                otherErrors++;
            end
            if ((migInValid && !migInReady) || (backendWValid && !backendWReady)) begin
                readyDropSeen = initSeen;
            end
            if (migInValid && migInReady) begin
                predict(migIn, 1'b1);
            end
            if (backendWValid && backendWReady) begin
                predict(backendWData, 1'b0);
            end
            if (backendRValid && backendRReady) begin
                checkOutput(backendRData, 1'b1);
            end
            if (migOutValid && migOutReady) begin
                checkOutput(migOut, 1'b0);
            end
            initSeen = initSeen || dramInitDone;
        end
    end

endmodule

// ==== bench/ClockGen.sv ====
/*
 * Testbench clock and synchronous reset source
 */
module ClockGen #(
    parameter int Period      = 100,
    parameter int ResetCycles = 2
) (
    output logic Clock,
    output logic rstN
);
    initial begin
        Clock = 1'b0;
        forever #(Period / 2) Clock = ~Clock;
    end

    // Release a little after the edge, like the other inputs
    initial begin
        rstN = 1'b0;
        repeat (ResetCycles) @(posedge Clock);
        #(Period / 10);
        rstN = 1'b1;
    end

endmodule

// ==== src/PathCrypt.sv ====
/*
 * Counter-mode encryption between the DRAM controller and the
 * Path ORAM backend, built from framer, keystream and output stages
 */
module PathCrypt (
    input  logic                Clock,
    input  logic                rstN,
    input  CryptPkg::BurstWordT migIn,
    input  logic                migInValid,
    output logic                migInReady,
    output CryptPkg::BurstWordT migOut,
    output logic                migOutValid,
    input  logic                migOutReady,
    input  CryptPkg::BurstWordT backendWData,
    input  logic                backendWValid,
    output logic                backendWReady,
    output CryptPkg::BurstWordT backendRData,
    output logic                backendRValid,
    input  logic                backendRReady,
    input  logic                dramInitDone
);
    import CryptPkg::*;

    // Framer to keystream
    IvT                    ivData;
    logic                  ivValid;
    logic                  ivReady;

    // Framer to output
    BurstWordT             dataWord;
    logic                  dataValid;
    logic                  dataReady;
    IvT                    ivCopy;
    logic                  ivCopyValid;
    logic                  ivCopyReady;
    logic                  dataIdle;

    // Keystream to output
    logic [BurstWidth-1:0] keyWord;
    logic                  keyValid;
    logic                  keyReady;

    BucketFramer bucketFramer (
        .Clock, .rstN,
        .migIn, .migInValid, .migInReady,
        .backendWData, .backendWValid, .backendWReady,
        .ivData, .ivValid, .ivReady,
        .dataWord, .dataValid, .dataReady,
        .ivCopy, .ivCopyValid, .ivCopyReady,
        .dataIdle
    );

    KeystreamGen keystreamGen (
        .Clock, .rstN,
        .ivData, .ivValid, .ivReady,
        .keyWord, .keyValid, .keyReady
    );

    OutputStage outputStage (
        .Clock, .rstN,
        .dataWord, .dataValid, .dataReady,
        .keyWord, .keyValid, .keyReady,
        .ivCopy, .ivCopyValid, .ivCopyReady,
        .dataIdle, .dramInitDone,
        .migOut, .migOutValid, .migOutReady,
        .backendRData, .backendRValid, .backendRReady
    );

endmodule

// ==== src/OutputStage.sv ====
/*
 * Output stage: XORs data with keystream, restores header IVs
 * and steers whole paths between the backend and DRAM sides
 */
module OutputStage (
    input  logic                            Clock,
    input  logic                            rstN,
    input  CryptPkg::BurstWordT             dataWord,
    input  logic                            dataValid,
    output logic                            dataReady,
    input  logic [CryptPkg::BurstWidth-1:0] keyWord,
    input  logic                            keyValid,
    output logic                            keyReady,
    input  CryptPkg::IvT                    ivCopy,
    input  logic                            ivCopyValid,
    output logic                            ivCopyReady,
    input  logic                            dataIdle,
    input  logic                            dramInitDone,
    output CryptPkg::BurstWordT             migOut,
    output logic                            migOutValid,
    input  logic                            migOutReady,
    output CryptPkg::BurstWordT             backendRData,
    output logic                            backendRValid,
    input  logic                            backendRReady
);
    import CryptPkg::*;

    localparam int PathCountWidth = $clog2(PathBursts);

    BurstWordT                 outWord;
    BucketIndexT               outPos;
    logic [PathCountWidth-1:0] pathCount;
    logic                      initDone;
    logic                      pathRead;
    logic                      isHeader;
    logic                      outValid;
    logic                      destReady;
    logic                      fire;

    // --------------------
    // Datapath
    // --------------------
    assign isHeader = (outPos == '0);

    always_comb begin
        outWord.raw = dataWord.raw ^ keyWord;
        // Header keeps its IV in the clear
        if (isHeader) begin
            outWord.header.iv = ivCopy;
        end
    end

    assign outValid  = initDone && dataValid && keyValid;
    assign destReady = pathRead ? backendRReady : migOutReady;
    assign fire      = outValid && destReady;

    assign dataReady   = fire;
    assign keyReady    = fire;
    assign ivCopyReady = fire && isHeader;

    assign migOut        = outWord;
    assign backendRData  = outWord;
    assign migOutValid   = outValid && !pathRead;
    assign backendRValid = outValid && pathRead;

    // --------------------
    // Control
    // --------------------
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            initDone  <= 1'b0;
            pathRead  <= 1'b0;
            outPos    <= '0;
            pathCount <= '0;
        end else begin
            // First path after init is a read
            if (!initDone && dramInitDone && dataIdle) begin
                initDone <= 1'b1;
                pathRead <= 1'b1;
            end
            if (fire) begin
                outPos <= (outPos == BucketIndexT'(BucketBursts - 1)) ? '0 : outPos + 1'b1;
                if (pathCount == PathCountWidth'(PathBursts - 1)) begin
                    pathCount <= '0;
                    pathRead  <= !pathRead;
                end else begin
                    pathCount <= pathCount + 1'b1;
                end
            end
        end
    end

    assert property (@(posedge Clock) disable iff (!rstN) (fire && isHeader) |-> ivCopyValid);

endmodule

// ==== src/KeystreamGen.sv ====
/*
 * Keystream generator: one request per burst of each queued IV,
 * a four-stage keyed mixing pipeline and a credit-guarded result FIFO
 */
module KeystreamGen (
    input  logic                            Clock,
    input  logic                            rstN,
    input  CryptPkg::IvT                    ivData,
    input  logic                            ivValid,
    output logic                            ivReady,
    output logic [CryptPkg::BurstWidth-1:0] keyWord,
    output logic                            keyValid,
    input  logic                            keyReady
);
    import CryptPkg::*;

    localparam int CreditWidth = $clog2(ResultDepth + 1);

    BucketIndexT                 burstIdx;
    logic [CreditWidth-1:0]      credits;
    logic [KeystreamLatency-1:0] stageValid;
    logic [BlockWidth-1:0]       counterBase;
    logic [BurstWidth-1:0]       resultWord;
    logic                        issue;
    logic                        resultPop;
    logic                        resultInReady;

    // --------------------
    // Request issue
    // --------------------
    // Credits cover in-flight requests plus queued results
    assign issue     = ivValid && (credits < CreditWidth'(ResultDepth));
    assign ivReady   = issue && (burstIdx == BucketIndexT'(BucketBursts - 1));
    assign resultPop = keyValid && keyReady;

    assign counterBase = BlockWidth'(ivData) + BlockWidth'(burstIdx) * BlockWidth'(Lanes);

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            burstIdx   <= '0;
            credits    <= '0;
            stageValid <= '0;
        end else begin
            if (issue) begin
                burstIdx <= (burstIdx == BucketIndexT'(BucketBursts - 1)) ? '0 : burstIdx + 1'b1;
            end
            case ({issue, resultPop})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
            stageValid <= {stageValid[KeystreamLatency-2:0], issue};
        end
    end

    // --------------------
    // Mixing pipeline
    // --------------------
    for (genvar n = 0; n < Lanes; n++) begin : gLane
        logic [BlockWidth-1:0] stage [KeystreamLatency];

        always_ff @(posedge Clock) begin
            stage[0] <= mixRound(counterBase + BlockWidth'(n), 0);
            for (int s = 1; s < KeystreamLatency; s++) begin
                stage[s] <= mixRound(stage[s-1], s);
            end
        end

        assign resultWord[n*BlockWidth +: BlockWidth] = stage[KeystreamLatency-1];
    end

    SyncFifo #(.Width(BurstWidth), .Depth(ResultDepth)) resultFifo (
        .Clock    (Clock),
        .rstN     (rstN),
        .inData   (resultWord),
        .inValid  (stageValid[KeystreamLatency-1]),
        .inReady  (resultInReady),
        .outData  (keyWord),
        .outValid (keyValid),
        .outReady (keyReady),
        .count    ()
    );

    // A result leaving the pipeline always finds room
    assert property (@(posedge Clock) disable iff (!rstN)
        stageValid[KeystreamLatency-1] |-> resultInReady);

endmodule

// ==== src/BucketFramer.sv ====
/*
 * Bucket framer: merges the two input sides, tracks the burst
 * position in the bucket and queues header IVs next to the data
 */
module BucketFramer (
    input  logic                Clock,
    input  logic                rstN,
    input  CryptPkg::BurstWordT migIn,
    input  logic                migInValid,
    output logic                migInReady,
    input  CryptPkg::BurstWordT backendWData,
    input  logic                backendWValid,
    output logic                backendWReady,
    output CryptPkg::IvT        ivData,
    output logic                ivValid,
    input  logic                ivReady,
    output CryptPkg::BurstWordT dataWord,
    output logic                dataValid,
    input  logic                dataReady,
    output CryptPkg::IvT        ivCopy,
    output logic                ivCopyValid,
    input  logic                ivCopyReady,
    output logic                dataIdle
);
    import CryptPkg::*;

    localparam int CountWidth = $clog2(FifoDepth + 1);

    BurstWordT             inWord;
    BucketIndexT           position;
    logic                  inValid;
    logic                  inReady;
    logic                  accept;
    logic                  isHeader;
    logic                  headerPush;
    logic                  ivInReady;
    logic                  ivCopyInReady;
    logic                  dataInReady;
    logic [CountWidth-1:0] dataCount;

    // --------------------
    // Input selection
    // --------------------
    assign inWord  = migInValid ? migIn : backendWData;
    assign inValid = migInValid || backendWValid;

    // Header needs room in all three queues
    assign isHeader      = (position == '0);
    assign inReady       = dataInReady && (!isHeader || (ivInReady && ivCopyInReady));
    assign migInReady    = inReady;
    assign backendWReady = inReady;

    assign accept     = inValid && inReady;
    assign headerPush = accept && isHeader;
    assign dataIdle   = (dataCount == '0);

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            position <= '0;
        end else if (accept) begin
            position <= (position == BucketIndexT'(BucketBursts - 1)) ? '0 : position + 1'b1;
        end
    end

    // --------------------
    // Queues
    // --------------------
    SyncFifo #(.Width(IvWidth), .Depth(FifoDepth)) ivFifo (
        .Clock    (Clock),
        .rstN     (rstN),
        .inData   (inWord.header.iv),
        .inValid  (headerPush),
        .inReady  (ivInReady),
        .outData  (ivData),
        .outValid (ivValid),
        .outReady (ivReady),
        .count    ()
    );

    // Second copy for restoring the header on output
    SyncFifo #(.Width(IvWidth), .Depth(FifoDepth)) ivCopyFifo (
        .Clock    (Clock),
        .rstN     (rstN),
        .inData   (inWord.header.iv),
        .inValid  (headerPush),
        .inReady  (ivCopyInReady),
        .outData  (ivCopy),
        .outValid (ivCopyValid),
        .outReady (ivCopyReady),
        .count    ()
    );

    SyncFifo #(.Width(BurstWidth), .Depth(FifoDepth)) dataFifo (
        .Clock    (Clock),
        .rstN     (rstN),
        .inData   (inWord.raw),
        .inValid  (accept),
        .inReady  (dataInReady),
        .outData  (dataWord),
        .outValid (dataValid),
        .outReady (dataReady),
        .count    (dataCount)
    );

    assert property (@(posedge Clock) disable iff (!rstN) !(migInValid && backendWValid));

endmodule

// ==== src/SyncFifo.sv ====
/*
 * Single-clock circular buffer with valid/ready on both sides
 * and a registered occupancy count
 */
module SyncFifo #(
    parameter int Width = 8,
    parameter int Depth = 4
) (
    input  logic                       Clock,
    input  logic                       rstN,
    input  logic [Width-1:0]           inData,
    input  logic                       inValid,
    output logic                       inReady,
    output logic [Width-1:0]           outData,
    output logic                       outValid,
    input  logic                       outReady,
    output logic [$clog2(Depth+1)-1:0] count
);
    localparam int PtrWidth   = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CountWidth = $clog2(Depth + 1);

    logic [Width-1:0]      mem [Depth];
    logic [PtrWidth-1:0]   wrPtr;
    logic [PtrWidth-1:0]   rdPtr;
    logic [CountWidth-1:0] countNext;
    logic                  push;
    logic                  pop;

    // Wraps at Depth, which need not be a power of two
    function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] p);
        return (p == PtrWidth'(Depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign push     = inValid && inReady;
    assign pop      = outValid && outReady;
    assign outValid = (count != '0);
    assign outData  = mem[rdPtr];

    always_comb begin
        countNext = count;
        if (push && !pop) begin
            countNext = count + 1'b1;
        end else if (pop && !push) begin
            countNext = count - 1'b1;
        end
    end

    always_ff @(posedge Clock) begin
        if (push) begin
            mem[wrPtr] <= inData;
        end
    end

    // Ready is registered, low through reset
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            wrPtr   <= '0;
            rdPtr   <= '0;
            count   <= '0;
            inReady <= 1'b0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            count   <= countNext;
            inReady <= (countNext < CountWidth'(Depth));
        end
    end

    assert property (@(posedge Clock) disable iff (!rstN) count <= CountWidth'(Depth));

endmodule

// ==== src/CryptPkg.sv ====
/*
 * Shared sizes, cipher constants and burst types for the
 * counter-mode path encryption stage
 */
package CryptPkg;

    // --------------------
    // Sizes
    // --------------------
    localparam int BurstWidth       = 128;
    localparam int IvWidth          = 32;
    localparam int BlockWidth       = 64;
    localparam int Lanes            = BurstWidth / BlockWidth;
    localparam int BucketBursts     = 4;
    localparam int PathBuckets      = 3;
    localparam int PathBursts       = BucketBursts * PathBuckets;
    localparam int FifoDepth        = 8;
    localparam int KeystreamLatency = 4;
    localparam int ResultDepth      = KeystreamLatency + 1;

    // --------------------
    // Cipher constants
    // --------------------
    localparam logic [BlockWidth-1:0] CipherKey   = 64'h0F1E_2D3C_4B5A_6978;
    localparam logic [BlockWidth-1:0] MixConstant = 64'h9E37_79B9_7F4A_7C15;

    typedef logic [IvWidth-1:0] IvT;
    typedef logic [1:0]         BucketIndexT;

    // Burst 0 of a bucket, IV in the low bits
    typedef struct packed {
        logic [BurstWidth-IvWidth-1:0] payload;
        IvT                            iv;
    } HeaderT;

    typedef union packed {
        logic [BurstWidth-1:0] raw;
        HeaderT                header;
    } BurstWordT;

    function automatic logic [BlockWidth-1:0] rotl(input logic [BlockWidth-1:0] x, input int k);
        return (x << k) | (x >> (BlockWidth - k));
    endfunction

    // One stage of the keyed mixing pipeline
    function automatic logic [BlockWidth-1:0] mixRound(input logic [BlockWidth-1:0] x,
                                                       input int s);
        logic [BlockWidth-1:0] t;
        t = x ^ rotl(CipherKey, 8 * s);
        t = rotl(t, 13);
        return t + MixConstant;
    endfunction

endpackage
